// File: files.f
logic/rv_pkg.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/rv_pipeline_top.sv
tests/tb_clock_gen.sv
tests/tb_rv_pipeline.sv

// File: logic/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage #(
  parameter int xlen = 64
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               instr_valid,
  input  logic [rv_pkg::INSTR_WIDTH-1:0]     instr,
  input  logic [xlen-1:0]                    rf_rdata1,
  input  logic [xlen-1:0]                    rf_rdata2,
  output logic                               dec_valid,
  output rv_pkg::alu_op_t                    dec_op,
  output rv_pkg::reg_addr_t                  dec_rd,
  output rv_pkg::reg_addr_t                  dec_rs1,
  output rv_pkg::reg_addr_t                  dec_rs2,
  output logic                               dec_wr_en,
  output logic                               dec_use_imm,
  output logic [xlen-1:0]                    dec_imm,
  output logic [xlen-1:0]                    dec_rs1_data,
  output logic [xlen-1:0]                    dec_rs2_data
);

  // funct3 / funct7 codes shared by the R and I forms
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub

  logic                           valid_q;
  logic [rv_pkg::INSTR_WIDTH-1:0] instr_q;
  logic [6:0]                     opcode;
  logic [2:0]                     funct3;
  logic [6:0]                     funct7;
  rv_pkg::alu_op_t                alu_op;
  logic                           legal;
  logic                           use_imm;

  // ------------------------------------------------------------
  // instruction register
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= instr_valid;  // idle cycle turns into a bubble
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      instr_q <= instr;
    end
  end

  // ------------------------------------------------------------
  // field decode
  // ------------------------------------------------------------
  assign opcode = instr_q[6:0];
  assign funct3 = instr_q[14:12];
  assign funct7 = instr_q[31:25];

  always_comb begin
    alu_op  = rv_pkg::ALU_ADD;
    legal   = 1'b1;
    use_imm = 1'b0;
    case (opcode)
      rv_pkg::OPC_REG: begin
        case (funct3)
          F3_ADD:  alu_op = (funct7 == F7_ALT) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          F3_SLL:  alu_op = rv_pkg::ALU_SLL;
          F3_SLT:  alu_op = rv_pkg::ALU_SLT;
          F3_XOR:  alu_op = rv_pkg::ALU_XOR;
          F3_SRL:  alu_op = rv_pkg::ALU_SRL;
          F3_OR:   alu_op = rv_pkg::ALU_OR;
          F3_AND:  alu_op = rv_pkg::ALU_AND;
          default: legal  = 1'b0;  // sltu
        endcase
        // only sub may carry the alternate funct7, so sra is rejected here
        if (funct7 != F7_BASE && !(funct3 == F3_ADD && funct7 == F7_ALT)) begin
          legal = 1'b0;
        end
      end
      rv_pkg::OPC_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          F3_ADD:  alu_op = rv_pkg::ALU_ADD;
          F3_SLT:  alu_op = rv_pkg::ALU_SLT;
          F3_XOR:  alu_op = rv_pkg::ALU_XOR;
          F3_OR:   alu_op = rv_pkg::ALU_OR;
          F3_AND:  alu_op = rv_pkg::ALU_AND;
          default: legal  = 1'b0;  // immediate shifts, sltiu
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  assign dec_valid   = valid_q;
  assign dec_op      = alu_op;
  assign dec_rd      = instr_q[11:7];
  assign dec_rs1     = instr_q[19:15];
  assign dec_rs2     = instr_q[24:20];
  assign dec_use_imm = use_imm;
  assign dec_wr_en   = valid_q && legal && (dec_rd != '0);  // x0 writes are dropped

  // sign extend from bit 11 of the immediate
  assign dec_imm = {{(xlen - rv_pkg::IMM_WIDTH){instr_q[rv_pkg::INSTR_WIDTH-1]}},
                    instr_q[rv_pkg::INSTR_WIDTH-1 -: rv_pkg::IMM_WIDTH]};

  assign dec_rs1_data = rf_rdata1;
  assign dec_rs2_data = rf_rdata2;

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage #(
  parameter int xlen = 64
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              dec_valid,
  input  rv_pkg::alu_op_t   dec_op,
  input  rv_pkg::reg_addr_t dec_rd,
  input  rv_pkg::reg_addr_t dec_rs1,
  input  rv_pkg::reg_addr_t dec_rs2,
  input  logic              dec_wr_en,
  input  logic              dec_use_imm,
  input  logic [xlen-1:0]   dec_imm,
  input  logic [xlen-1:0]   dec_rs1_data,
  input  logic [xlen-1:0]   dec_rs2_data,
  input  logic              wb_wr_en,
  input  rv_pkg::reg_addr_t wb_rd,
  input  logic [xlen-1:0]   wb_data,
  output logic              ex_valid,
  output rv_pkg::reg_addr_t ex_rd,
  output logic              ex_wr_en,
  output logic [xlen-1:0]   ex_result
);

  localparam int SHAMT_W = $clog2(xlen);

  logic              valid_q;
  logic              wr_en_q;
  rv_pkg::alu_op_t   op_q;
  rv_pkg::reg_addr_t rd_q;
  rv_pkg::reg_addr_t rs1_q;
  rv_pkg::reg_addr_t rs2_q;
  logic              use_imm_q;
  logic [xlen-1:0]   imm_q;
  logic [xlen-1:0]   rs1_data_q;
  logic [xlen-1:0]   rs2_data_q;

  logic              fwd_a;
  logic              fwd_b;
  logic [xlen-1:0]   opnd_a;
  logic [xlen-1:0]   rs2_val;
  logic [xlen-1:0]   opnd_b;
  logic [SHAMT_W-1:0] shamt;

  // ------------------------------------------------------------
  // execute register
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      wr_en_q <= 1'b0;
    end else begin
      valid_q <= dec_valid;
      wr_en_q <= dec_wr_en;
    end
  end

  always_ff @(posedge clk) begin
    op_q       <= dec_op;
    rd_q       <= dec_rd;
    rs1_q      <= dec_rs1;
    rs2_q      <= dec_rs2;
    use_imm_q  <= dec_use_imm;
    imm_q      <= dec_imm;
    rs1_data_q <= dec_rs1_data;
    rs2_data_q <= dec_rs2_data;
  end

  // ------------------------------------------------------------
  // operand select
  // ------------------------------------------------------------
  // producer one slot ahead is now in writeback and not yet in the regfile
  assign fwd_a = wb_wr_en && (wb_rd == rs1_q) && (rs1_q != '0);
  assign fwd_b = wb_wr_en && (wb_rd == rs2_q) && (rs2_q != '0);

  assign opnd_a  = fwd_a ? wb_data : rs1_data_q;
  assign rs2_val = fwd_b ? wb_data : rs2_data_q;
  assign opnd_b  = use_imm_q ? imm_q : rs2_val;

  assign shamt = opnd_b[SHAMT_W-1:0];  // low log2(xlen) bits only

  // ------------------------------------------------------------
  // alu
  // ------------------------------------------------------------
  always_comb begin
    case (op_q)
      rv_pkg::ALU_ADD: ex_result = opnd_a + opnd_b;  // wraps
      rv_pkg::ALU_SUB: ex_result = opnd_a - opnd_b;
      rv_pkg::ALU_AND: ex_result = opnd_a & opnd_b;
      rv_pkg::ALU_OR:  ex_result = opnd_a | opnd_b;
      rv_pkg::ALU_XOR: ex_result = opnd_a ^ opnd_b;
      rv_pkg::ALU_SLT: ex_result = {{(xlen-1){1'b0}}, $signed(opnd_a) < $signed(opnd_b)};
      rv_pkg::ALU_SLL: ex_result = opnd_a << shamt;
      rv_pkg::ALU_SRL: ex_result = opnd_a >> shamt;  // logical
      default:         ex_result = opnd_a + opnd_b;
    endcase
  end

  assign ex_valid = valid_q;
  assign ex_rd    = rd_q;
  assign ex_wr_en = wr_en_q;

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file #(
  parameter int xlen = 64
) (
  input  logic              clk,
  input  logic              rst_n,
  input  rv_pkg::reg_addr_t raddr1,
  input  rv_pkg::reg_addr_t raddr2,
  output logic [xlen-1:0]   rdata1,
  output logic [xlen-1:0]   rdata2,
  input  logic              we,
  input  rv_pkg::reg_addr_t waddr,
  input  logic [xlen-1:0]   wdata
);

  // x0 has no storage
  logic [xlen-1:0] regs [1:rv_pkg::NUM_REGS-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // write-through so a reader two slots behind the producer sees the new value
  function automatic logic [xlen-1:0] read_port(input rv_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (we && addr == waddr) begin
      return wdata;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rdata1 = read_port(raddr1);
    rdata2 = read_port(raddr2);
  end

endmodule

`default_nettype wire

// File: logic/rv_pipeline_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_pipeline_top #(
  parameter int xlen = 64
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           instr_valid,
  input  logic [rv_pkg::INSTR_WIDTH-1:0] instr,
  output logic                           wb_valid,
  output rv_pkg::reg_addr_t              wb_rd,
  output logic [xlen-1:0]                wb_data
);

  // ------------------------------------------------------------
  // decode -> execute
  // ------------------------------------------------------------
  logic              dec_valid;
  rv_pkg::alu_op_t   dec_op;
  rv_pkg::reg_addr_t dec_rd;
  rv_pkg::reg_addr_t dec_rs1;
  rv_pkg::reg_addr_t dec_rs2;
  logic              dec_wr_en;
  logic              dec_use_imm;
  logic [xlen-1:0]   dec_imm;
  logic [xlen-1:0]   dec_rs1_data;
  logic [xlen-1:0]   dec_rs2_data;
  logic [xlen-1:0]   rf_rdata1;
  logic [xlen-1:0]   rf_rdata2;

  // execute -> writeback, writeback -> regfile and forwarding
  logic              ex_valid;
  rv_pkg::reg_addr_t ex_rd;
  logic              ex_wr_en;
  logic [xlen-1:0]   ex_result;
  logic              wb_wr_en;

  decode_stage #(.xlen(xlen)) u_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .rf_rdata1    (rf_rdata1),
    .rf_rdata2    (rf_rdata2),
    .dec_valid    (dec_valid),
    .dec_op       (dec_op),
    .dec_rd       (dec_rd),
    .dec_rs1      (dec_rs1),
    .dec_rs2      (dec_rs2),
    .dec_wr_en    (dec_wr_en),
    .dec_use_imm  (dec_use_imm),
    .dec_imm      (dec_imm),
    .dec_rs1_data (dec_rs1_data),
    .dec_rs2_data (dec_rs2_data)
  );

  reg_file #(.xlen(xlen)) u_reg_file (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr1 (dec_rs1),
    .raddr2 (dec_rs2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .we     (wb_wr_en),
    .waddr  (wb_rd),
    .wdata  (wb_data)
  );

  execute_stage #(.xlen(xlen)) u_execute (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec_valid    (dec_valid),
    .dec_op       (dec_op),
    .dec_rd       (dec_rd),
    .dec_rs1      (dec_rs1),
    .dec_rs2      (dec_rs2),
    .dec_wr_en    (dec_wr_en),
    .dec_use_imm  (dec_use_imm),
    .dec_imm      (dec_imm),
    .dec_rs1_data (dec_rs1_data),
    .dec_rs2_data (dec_rs2_data),
    .wb_wr_en     (wb_wr_en),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .ex_valid     (ex_valid),
    .ex_rd        (ex_rd),
    .ex_wr_en     (ex_wr_en),
    .ex_result    (ex_result)
  );

  writeback_stage #(.xlen(xlen)) u_writeback (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex_valid  (ex_valid),
    .ex_rd     (ex_rd),
    .ex_wr_en  (ex_wr_en),
    .ex_result (ex_result),
    .wb_valid  (wb_valid),
    .wb_wr_en  (wb_wr_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

endmodule

`default_nettype wire

// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  localparam int NUM_REGS    = 32;  // architectural registers, x0 included
  localparam int IMM_WIDTH   = 12;  // I-type immediate
  localparam int INSTR_WIDTH = 32;

  typedef logic [4:0] reg_addr_t;

  // ------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------
  // major opcodes handled by this core
  typedef enum logic [6:0] {
    OPC_REG = 7'b0110011,  // add, sub, and, or, xor, slt, sll, srl
    OPC_IMM = 7'b0010011   // addi, andi, ori, xori, slti
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD = 4'h0,
    ALU_SUB = 4'h1,
    ALU_AND = 4'h2,
    ALU_OR  = 4'h3,
    ALU_XOR = 4'h4,
    ALU_SLT = 4'h5,  // signed compare
    ALU_SLL = 4'h6,
    ALU_SRL = 4'h7
  } alu_op_t;

endpackage

`default_nettype wire

// File: logic/writeback_stage.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_stage #(
  parameter int xlen = 64
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ex_valid,
  input  rv_pkg::reg_addr_t ex_rd,
  input  logic              ex_wr_en,
  input  logic [xlen-1:0]   ex_result,
  output logic              wb_valid,
  output logic              wb_wr_en,
  output rv_pkg::reg_addr_t wb_rd,
  output logic [xlen-1:0]   wb_data
);

  logic              valid_q;
  logic              wr_en_q;
  rv_pkg::reg_addr_t rd_q;
  logic [xlen-1:0]   data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      wr_en_q <= 1'b0;
    end else begin
      valid_q <= ex_valid;
      wr_en_q <= ex_wr_en;
    end
  end

  always_ff @(posedge clk) begin
    rd_q   <= ex_rd;
    data_q <= ex_result;
  end

  // only a valid, register-writing instruction is reported
  assign wb_valid = valid_q && wr_en_q;
  assign wb_wr_en = wr_en_q;   // regfile commits at the edge closing this cycle
  assign wb_rd    = rd_q;
  assign wb_data  = data_q;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the testbench from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_rv_pipeline -f files.f -o tb_sim \
  && out=$(./obj_dir/tb_sim) \
  && echo "$out" \
  && echo "$out" | grep -q "SIMULATION PASSED" \
  || { echo "run failed"; exit 1; }
echo "run passed"

// File: tests/rv_testdata.txt
// columns: ctrl instr rd value (hex, one instruction per line)
// ctrl bit0 expects a writeback of value to rd, bit1 issues with no idle gap
1 00500093 01 0000000000000005 // addi x1, x0, 5
1 FFF00113 02 FFFFFFFFFFFFFFFF // addi x2, x0, -1
1 7FF00193 03 00000000000007FF // addi x3, x0, 2047
1 80000213 04 FFFFFFFFFFFFF800 // addi x4, x0, -2048
1 003082B3 05 0000000000000804 // add x5, x1, x3
1 40308333 06 FFFFFFFFFFFFF806 // sub x6, x1, x3
1 003173B3 07 00000000000007FF // and x7, x2, x3
1 0040E433 08 FFFFFFFFFFFFF805 // or x8, x1, x4
1 001144B3 09 FFFFFFFFFFFFFFFA // xor x9, x2, x1
1 00122533 0A 0000000000000001 // slt x10, x4, x1
1 0040A5B3 0B 0000000000000000 // slt x11, x1, x4
1 00309633 0C 8000000000000000 // sll x12, x1, x3
1 003156B3 0D 0000000000000001 // srl x13, x2, x3
1 00125733 0E 07FFFFFFFFFFFFC0 // srl x14, x4, x1
1 0F017793 0F 00000000000000F0 // andi x15, x2, 0xf0
1 FF00E813 10 FFFFFFFFFFFFFFF5 // ori x16, x1, -16
1 FFF1C893 11 FFFFFFFFFFFFF800 // xori x17, x3, -1
1 00012913 12 0000000000000001 // slti x18, x2, 0
1 FFF0A993 13 0000000000000000 // slti x19, x1, -1
0 00708013 00 0000000000000000 // addi x0, x1, 7
1 00100A33 14 0000000000000005 // add x20, x0, x1
0 0000AA83 00 0000000000000000 // lw x21, 0(x1) unsupported opcode
0 40115B33 00 0000000000000000 // sra x22, x2, x1 unsupported funct7
1 01600BB3 17 0000000000000000 // add x23, x0, x22
1 06400C13 18 0000000000000064 // addi x24, x0, 100
3 001C0C93 19 0000000000000065 // addi x25, x24, 1
3 019C0D33 1A 00000000000000C9 // add x26, x24, x25
3 418D0DB3 1B 0000000000000065 // sub x27, x26, x24
3 019DCE33 1C 0000000000000000 // xor x28, x27, x25
2 003E0013 00 0000000000000000 // addi x0, x28, 3
3 000D0EB3 1D 00000000000000C9 // add x29, x26, x0
3 01ADAF33 1E 0000000000000001 // slt x30, x27, x26
3 018F1FB3 1F 0000001000000000 // sll x31, x30, x24
3 01EFD0B3 01 0000000800000000 // srl x1, x31, x30
3 FFF08113 02 00000007FFFFFFFF // addi x2, x1, -1

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int period       = 8,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;  // release away from the active edge
  end

endmodule

`default_nettype wire

// File: tests/tb_rv_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_pipeline;

  localparam int xlen           = 64;
  localparam int num_instr      = 35;  // lines in the data file
  localparam int clk_period     = 8;
  localparam int timeout_cycles = num_instr * 4 + 50;

  logic                           clk;
  logic                           rst_n;
  logic                           instr_valid;
  logic [rv_pkg::INSTR_WIDTH-1:0] instr;
  logic                           wb_valid;
  rv_pkg::reg_addr_t              wb_rd;
  logic [xlen-1:0]                wb_data;

  // four words per instruction in the order ctrl, instr, rd, value
  logic [63:0]     testdata [0:4*num_instr-1];
  logic [4:0]      exp_rd_q[$];
  logic [xlen-1:0] exp_data_q[$];
  int              exp_cyc_q[$];

  int          errors = 0;
  int          checks = 0;
  int          cyc    = 0;
  logic [31:0] lfsr;

  tb_clock_gen #(.period(clk_period), .reset_cycles(2)) u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rv_pipeline_top #(.xlen(xlen)) uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

  always @(posedge clk) cyc <= cyc + 1;

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, want);
    end
  endtask

  // one instruction per negedge, random idle gaps outside back-to-back runs
  task automatic run_program();
    int          gap;
    logic [63:0] ctrl;
    for (int i = 0; i < num_instr; i++) begin
      ctrl = testdata[4*i];
      if (!ctrl[1]) begin
        take_bits(2, gap);
        gap         = gap % 3;
        instr_valid = 1'b0;
        repeat (gap) @(negedge clk);
      end
      instr_valid = 1'b1;
      instr       = testdata[4*i+1][31:0];
      if (ctrl[0]) begin
        exp_rd_q.push_back(testdata[4*i+2][4:0]);
        exp_data_q.push_back(testdata[4*i+3]);
        exp_cyc_q.push_back(cyc + 3);  // accepted at next edge, shown two edges later
      end
      @(negedge clk);
    end
    instr_valid = 1'b0;
  endtask

  // ------------------------------------------------------------
  // writeback monitor
  // ------------------------------------------------------------
  always @(negedge clk) begin
    logic [4:0]      want_rd;
    logic [xlen-1:0] want_data;
    int              want_cyc;
    if (wb_valid === 1'b1) begin
      if (exp_rd_q.size() == 0) begin
        errors++;
        $display("unexpected writeback to x%0d at %0t with nothing outstanding",
                 wb_rd, $time);
      end else begin
        want_rd   = exp_rd_q.pop_front();
        want_data = exp_data_q.pop_front();
        want_cyc  = exp_cyc_q.pop_front();
        check_value("wb_rd", {59'd0, wb_rd}, {59'd0, want_rd});
        check_value("wb_data", wb_data, want_data);
        check_value("wb_cycle", 64'(cyc), 64'(want_cyc));
      end
    end
  end

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    instr_valid = 1'b0;
    instr       = '0;
    lfsr        = 32'he9501ed7;
    $readmemh("tests/rv_testdata.txt", testdata);
    // the last line must hold a real instruction word
    if ($isunknown(testdata[4*num_instr-3]) || testdata[4*num_instr-3] == '0) begin
      errors++;
      $display("test data file tests/rv_testdata.txt could not be read or is too short");
    end else begin
      wait (rst_n === 1'b1);
      @(negedge clk);
      run_program();
      while (exp_rd_q.size() != 0) @(posedge clk);
      repeat (4) @(posedge clk);  // window for stray writebacks
    end
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(timeout_cycles * clk_period);
    $display("timeout after %0d cycles with %0d writebacks still outstanding",
             timeout_cycles, exp_rd_q.size());
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire
